//--- logic/regfile_pkg.sv
package regfile_pkg;

	// storage geometry
	localparam int WORD_W = 32;     // bits per register
	localparam int ADDR_W = 5;      // register index width
	localparam int BYTES_PER_WORD = WORD_W / 8;
	localparam int NUM_REGS = 32;   // words in the file
	localparam int ZERO_REG = 0;    // hardwired zero, like a cpu r0

	typedef logic [WORD_W-1:0] word_t;              // one register word
	typedef logic [ADDR_W-1:0] reg_addr_t;          // register index
	typedef logic [BYTES_PER_WORD-1:0] byte_sel_t;  // one enable per byte lane

	// write command from the bus stage into storage
	// strobe is high for exactly one cycle per accepted write
	typedef struct packed {
		logic      strobe;  // commit this cycle
		reg_addr_t addr;    // target register
		byte_sel_t sel;     // lanes to update
		word_t     data;    // new lane contents
	} wr_cmd_t;

endpackage

//--- logic/bus_pkg.sv
package bus_pkg;

	import regfile_pkg::*;

	// wishbone byte address
	// bits 6..2 pick the register, 1..0 are don't care
	localparam int WB_ADR_W = 7;
	localparam int REG_IDX_LSB = 2;  // word aligned, low two bits dropped

	typedef logic [WB_ADR_W-1:0] wb_adr_t;

	// master to slave, classic single cycles only
	typedef struct packed {
		logic      cyc;  // bus cycle in progress
		logic      stb;  // strobe, valid transfer
		logic      we;   // 1 write, 0 read
		wb_adr_t   adr;  // byte address
		byte_sel_t sel;  // byte enables
		word_t     dat;  // write data
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic  ack;  // one cycle per strobe
		word_t dat;  // read data, valid with ack
	} wb_rsp_t;

	// display side
	localparam int LED_W = 8;          // led bank width
	localparam int PANEL_DIV_BIT = 4;  // rising edge of this bit is a tick, every 32 clocks
	localparam int PANEL_DIV_W = PANEL_DIV_BIT + 1;  // counter only needs to reach the tick bit

	typedef logic [LED_W-1:0] led_t;

endpackage

//--- logic/wb_reg_port.sv
`timescale 1ns/100ps

module wb_reg_port
	import regfile_pkg::*, bus_pkg::*;
(
	input  logic      orig_clk,
	input  logic      rst,
	input  wb_req_t   wb_i,     // from bus master
	output wb_rsp_t   wb_o,     // back to bus master
	output wr_cmd_t   wr_cmd,   // write into storage
	output reg_addr_t rd_addr,  // read port 1 index
	input  word_t     rd_data   // read port 1 data, combinational
);

	// idle -> respond -> wait_release -> idle
	typedef enum logic [1:0] {
		st_idle,
		st_respond,
		st_wait_release
	} state_t;

	state_t    state;
	logic      req_valid;  // cyc and stb both high
	logic      wr_strobe;  // one cycle write pulse
	logic      ack_q;
	reg_addr_t req_idx;    // latched register index
	byte_sel_t req_sel;
	word_t     req_dat;
	word_t     rsp_dat;    // read data held for the ack cycle

	assign req_valid = wb_i.cyc && wb_i.stb;

	// control path
	always_ff @(posedge orig_clk) begin
		if (rst) begin
			state     <= st_idle;
			wr_strobe <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			wr_strobe <= 1'b0;  // pulses by default
			ack_q     <= 1'b0;
			case (state)
				st_idle: begin
					if (req_valid) begin  // new strobe sampled here, edge n
						state     <= st_respond;
						wr_strobe <= wb_i.we;  // storage commits at n+1
					end
				end
				st_respond: begin
					// master may have dropped cyc, then no ack
					ack_q <= req_valid;
					state <= st_wait_release;
				end
				st_wait_release: begin
					if (!req_valid)  // held stb is not a second request
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request payload, latched on acceptance
	always_ff @(posedge orig_clk) begin
		if (state == st_idle && req_valid) begin
			req_idx <= wb_i.adr[WB_ADR_W-1:REG_IDX_LSB];  // drop byte offset
			req_sel <= wb_i.sel;
			req_dat <= wb_i.dat;
		end
	end

	// read data captured alongside ack
	always_ff @(posedge orig_clk) begin
		if (state == st_respond)
			rsp_dat <= rd_data;  // req_idx already steady on read port 1
	end

	assign rd_addr = req_idx;

	always_comb begin
		wr_cmd.strobe = wr_strobe;
		wr_cmd.addr   = req_idx;
		wr_cmd.sel    = req_sel;
		wr_cmd.data   = req_dat;
	end

	always_comb begin
		wb_o.ack = ack_q;
		wb_o.dat = rsp_dat;  // only meaningful while ack is high
	end

endmodule

//--- logic/file_register.sv
`timescale 1ns/100ps

module file_register
	import regfile_pkg::*;
(
	input  logic      orig_clk,
	input  logic      rst,
	input  wr_cmd_t   wr_cmd,      // single write port
	input  reg_addr_t read0_addr,  // display side
	output word_t     read0_data,
	input  reg_addr_t read1_addr,  // bus side
	output word_t     read1_data
);

	word_t               regs [NUM_REGS];
	logic [NUM_REGS-1:0] wr_en;   // one-hot write decode
	word_t               old_word;
	word_t               merged;  // old word with selected lanes replaced

	// 5 to 32 decoder, r0 never enabled
	always_comb begin
		wr_en = '0;
		if (wr_cmd.strobe && wr_cmd.addr != reg_addr_t'(ZERO_REG))
			wr_en[wr_cmd.addr] = 1'b1;
	end

	assign old_word = regs[wr_cmd.addr];

	// per lane 2:1 mux between new and old byte
	always_comb begin
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			merged[8*b +: 8] = wr_cmd.sel[b] ? wr_cmd.data[8*b +: 8] : old_word[8*b +: 8];
		end
	end

	// storage flops
	always_ff @(posedge orig_clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;  // whole file starts at zero
		end else begin
			for (int i = 0; i < NUM_REGS; i++) begin
				if (wr_en[i])
					regs[i] <= merged;
			end
		end
	end

	// read ports, combinational
	// r0 forced to zero on the output as well
	assign read0_data = (read0_addr == reg_addr_t'(ZERO_REG)) ? '0 : regs[read0_addr];
	assign read1_data = (read1_addr == reg_addr_t'(ZERO_REG)) ? '0 : regs[read1_addr];

endmodule

//--- logic/led_panel.sv
`timescale 1ns/100ps

module led_panel
	import regfile_pkg::*, bus_pkg::*;
(
	input  logic      orig_clk,
	input  logic      rst,
	input  reg_addr_t sel,        // switch setting, register to show
	output reg_addr_t read_addr,  // to read port 0
	input  word_t     read_data,  // from read port 0
	output led_t      led
);

	logic [PANEL_DIV_W-1:0] div_cnt;  // free running divider
	logic                   div_bit_q;  // tick bit one cycle ago
	logic                   tick;       // one clock pulse per period

	// no derived clock, the divider only gives an enable
	always_ff @(posedge orig_clk) begin
		if (rst) begin
			div_cnt   <= '0;
			div_bit_q <= 1'b0;
		end else begin
			div_cnt   <= div_cnt + 1'b1;  // wraps
			div_bit_q <= div_cnt[PANEL_DIV_BIT];
		end
	end

	assign tick = div_cnt[PANEL_DIV_BIT] && !div_bit_q;  // rising edge of tick bit

	assign read_addr = sel;  // switches drive the index straight

	// display latch, low byte only
	always_ff @(posedge orig_clk) begin
		if (rst)
			led <= '0;
		else if (tick)
			led <= read_data[LED_W-1:0];
	end

endmodule

//--- logic/file_reg_system.sv
`timescale 1ns/100ps

module file_reg_system
	import regfile_pkg::*, bus_pkg::*;
(
	input  logic      orig_clk,
	input  logic      rst,
	input  wb_req_t   wb_i,  // wishbone master side
	output wb_rsp_t   wb_o,
	input  reg_addr_t sel,   // display register select
	output led_t      led
);

	wr_cmd_t   wr_cmd;         // bus stage to storage
	reg_addr_t bus_rd_addr;    // read port 1
	word_t     bus_rd_data;
	reg_addr_t panel_rd_addr;  // read port 0
	word_t     panel_rd_data;

	// bus stage
	wb_reg_port u_wb_reg_port (
		.orig_clk (orig_clk),
		.rst      (rst),
		.wb_i     (wb_i),
		.wb_o     (wb_o),
		.wr_cmd   (wr_cmd),
		.rd_addr  (bus_rd_addr),
		.rd_data  (bus_rd_data)
	);

	// storage, port 0 for display and port 1 for bus
	file_register u_file_register (
		.orig_clk   (orig_clk),
		.rst        (rst),
		.wr_cmd     (wr_cmd),
		.read0_addr (panel_rd_addr),
		.read0_data (panel_rd_data),
		.read1_addr (bus_rd_addr),
		.read1_data (bus_rd_data)
	);

	// side reader for the leds
	led_panel u_led_panel (
		.orig_clk  (orig_clk),
		.rst       (rst),
		.sel       (sel),
		.read_addr (panel_rd_addr),
		.read_data (panel_rd_data),
		.led       (led)
	);

endmodule

//--- tests/wb_slave_checker.sv
`timescale 1ns/100ps

module wb_slave_checker
	import regfile_pkg::*, bus_pkg::*;
(
	input logic    orig_clk,
	input logic    rst,
	input wb_req_t wb_i,
	input wb_rsp_t wb_o,
	input led_t    led
);

	logic req_valid;  // master has an active strobe

	assign req_valid = wb_i.cyc && wb_i.stb;

	// classic handshake, the edge that ends the transfer sees ack with cyc and stb
	ack_with_strobe: assert property (
		@(posedge orig_clk) disable iff (rst)
		wb_o.ack |-> req_valid
	) else $error("ack without cyc and stb");

	ack_one_cycle: assert property (
		@(posedge orig_clk) disable iff (rst)
		wb_o.ack |=> !wb_o.ack
	) else $error("ack held longer than one cycle");

	// new strobe sampled at n, ack set at n+1, sampled here at n+2
	ack_after_new_strobe: assert property (
		@(posedge orig_clk) disable iff (rst)
		($past(req_valid, 2) && !$past(req_valid, 3)) |-> wb_o.ack
	) else $error("no ack on the edge after a new strobe");

	// first edge out of reset
	quiet_after_reset: assert property (
		@(posedge orig_clk)
		$fell(rst) |-> (!wb_o.ack && led == '0)
	) else $error("ack or led not zero right after reset");

endmodule

bind file_reg_system wb_slave_checker u_wb_slave_checker (
	.orig_clk (orig_clk),
	.rst      (rst),
	.wb_i     (wb_i),
	.wb_o     (wb_o),
	.led      (led)
);

//--- tests/tb_file_reg_system.sv
`timescale 1ns/100ps

module tb_file_reg_system
	import regfile_pkg::*, bus_pkg::*;
();

	localparam int CLK_HALF     = 50;                  // 100 ns period
	localparam int RESET_CYCLES = 16;
	localparam int MAX_TRANS    = 64;                  // pattern file capacity
	localparam int FIELDS       = 5;                   // op, adr, sel, data, expected
	localparam int ACK_TIMEOUT  = 16;                  // cycles, real latency is 1
	localparam int ACK_NEGEDGE  = 2;                   // ack seen on the second falling edge
	localparam int TICK_PERIOD  = 2 << PANEL_DIV_BIT;  // 32 clocks between ticks
	localparam int LED_TIMEOUT  = 2 * TICK_PERIOD;
	localparam logic [16:0] LFSR_SEED = 17'd79624;

	// opcodes in the first column of the pattern file
	localparam word_t OP_END   = 32'h0;
	localparam word_t OP_WRITE = 32'h1;
	localparam word_t OP_READ  = 32'h2;
	localparam word_t OP_LED   = 32'h3;

	logic      orig_clk;
	logic      rst;
	wb_req_t   wb_i;   // master side, driven here
	wb_rsp_t   wb_o;
	reg_addr_t sel;    // stands in for the switches
	led_t      led;

	word_t       patterns [MAX_TRANS*FIELDS];  // flat, five words per transaction
	logic [16:0] lfsr;                         // idle gap source
	int          value_errors;
	int          timeouts;
	int          protocol_errors;

	file_reg_system dut (
		.orig_clk (orig_clk),
		.rst      (rst),
		.wb_i     (wb_i),
		.wb_o     (wb_o),
		.sel      (sel),
		.led      (led)
	);

	initial orig_clk = 1'b0;
	always #(CLK_HALF) orig_clk = ~orig_clk;

	// x^17 + x^14 + 1, maximal length
	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	// 0 to 3 idle cycles, two lfsr bits
	task automatic random_idle();
		int gap;
		gap = 0;
		for (int k = 0; k < 2; k++) begin
			lfsr = lfsr_step(lfsr);     // one step per bit taken
			gap  = gap * 2 + int'(lfsr[0]);
		end
		repeat (gap) @(negedge orig_clk);
	endtask

	// one classic single cycle, called on a falling edge
	task automatic bus_cycle(input logic wr, input wb_adr_t adr, input byte_sel_t bsel,
			input word_t wdat, output word_t rdat);
		int   waited;
		logic got_ack;
		waited   = 0;
		got_ack  = 1'b0;
		wb_i.cyc = 1'b1;  // held until ack
		wb_i.stb = 1'b1;
		wb_i.we  = wr;
		wb_i.adr = adr;
		wb_i.sel = bsel;
		wb_i.dat = wdat;
		while (!got_ack && waited < ACK_TIMEOUT) begin
			@(negedge orig_clk);  // mid cycle, ack is settled
			waited++;
			got_ack = wb_o.ack;
		end
		rdat = wb_o.dat;  // only valid in the ack cycle
		if (!got_ack) begin
			$display("ERROR: no ack within %0d cycles for a %s at address %h",
				ACK_TIMEOUT, wr ? "write" : "read", adr);
			timeouts++;
		end else begin
			if (waited != ACK_NEGEDGE) begin
				$display("ERROR: ack came after %0d cycles instead of %0d at address %h",
					waited, ACK_NEGEDGE, adr);
				protocol_errors++;
			end
			@(negedge orig_clk);  // stb still held across the ack edge
			if (wb_o.ack) begin  // held stb must not earn a second ack
				$display("ERROR: ack stayed high for a second cycle at address %h", adr);
				protocol_errors++;
			end
		end
		wb_i.cyc = 1'b0;  // release
		wb_i.stb = 1'b0;
		wb_i.we  = 1'b0;
		@(negedge orig_clk);  // stb low for at least one edge
	endtask

	// set the switches and wait for the display to follow
	task automatic led_wait(input reg_addr_t idx, input led_t expected);
		int waited;
		waited = 0;
		sel    = idx;
		while (led !== expected && waited < LED_TIMEOUT) begin
			@(negedge orig_clk);
			waited++;
		end
		if (led !== expected) begin
			$display("FAILED led: got %h expected %h, register %0d, no match in %0d cycles",
				led, expected, idx, LED_TIMEOUT);
			value_errors++;
		end
	endtask

	initial begin
		word_t     op;
		word_t     exp_val;
		word_t     wdat;
		word_t     rdat;
		wb_adr_t   adr;
		byte_sel_t bsel;
		int        t;
		logic      done;
		rst             = 1'b1;
		wb_i            = '0;
		sel             = '0;
		lfsr            = LFSR_SEED;
		value_errors    = 0;
		timeouts        = 0;
		protocol_errors = 0;
		for (int i = 0; i < MAX_TRANS*FIELDS; i++)
			patterns[i] = '0;  // unread entries decode as end
		$readmemh("tests/regfile_patterns.hex", patterns);

		repeat (RESET_CYCLES) @(negedge orig_clk);
		rst = 1'b0;
		@(negedge orig_clk);

		// quiet outputs before any traffic
		if (wb_o.ack !== 1'b0) begin
			$display("FAILED wb_o.ack after reset: got %h expected %h", wb_o.ack, 1'b0);
			value_errors++;
		end
		if (led !== '0) begin
			$display("FAILED led after reset: got %h expected %h", led, 8'h00);
			value_errors++;
		end

		t    = 0;
		done = 1'b0;
		while (!done && t < MAX_TRANS) begin
			op      = patterns[t*FIELDS];
			adr     = wb_adr_t'(patterns[t*FIELDS+1]);
			bsel    = byte_sel_t'(patterns[t*FIELDS+2]);
			wdat    = patterns[t*FIELDS+3];
			exp_val = patterns[t*FIELDS+4];
			case (op)
				OP_WRITE: bus_cycle(1'b1, adr, bsel, wdat, rdat);
				OP_READ: begin
					bus_cycle(1'b0, adr, bsel, '0, rdat);
					if (rdat !== exp_val) begin
						$display("FAILED wb_o.dat: transaction %0d address %h got %h expected %h",
							t, adr, rdat, exp_val);
						value_errors++;
					end
				end
				OP_LED: led_wait(adr[WB_ADR_W-1:REG_IDX_LSB], led_t'(exp_val));  // word index
				OP_END: done = 1'b1;
				default: begin
					$display("ERROR: unknown opcode %h in transaction %0d", op, t);
					protocol_errors++;
					done = 1'b1;
				end
			endcase
			if (!done) begin
				random_idle();
				t++;
			end
		end

		if (t == 0) begin  // missing or empty pattern file
			$display("ERROR: no transactions were read from the pattern file");
			protocol_errors++;
		end

		$display("%0d transactions, %0d wrong values, %0d timeouts, %0d protocol errors",
			t, value_errors, timeouts, protocol_errors);
		if (value_errors + timeouts + protocol_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- tests/regfile_patterns.hex
// columns: op adr sel data expected; op 1 write, 2 read, 3 led check, 0 end
// led check selects the register at adr; unused columns are zero or f
2 04 f 00000000 00000000
2 40 f 00000000 00000000
2 7c f 00000000 00000000
3 0c 0 00000000 00000000
1 04 f 11223344 00000000
2 04 f 00000000 11223344
1 08 f a5a5a5a5 00000000
2 08 f 00000000 a5a5a5a5
1 7c f deadbeef 00000000
2 7c f 00000000 deadbeef
1 41 f 0badf00d 00000000
2 42 f 00000000 0badf00d
1 14 f cafef00d 00000000
1 14 1 000000aa 00000000
2 14 f 00000000 cafef0aa
1 14 6 12345678 00000000
2 14 f 00000000 ca3456aa
1 14 8 99000000 00000000
2 17 f 00000000 993456aa
1 04 3 0000beef 00000000
2 04 f 00000000 1122beef
1 1c 5 11223344 00000000
2 1c f 00000000 00220044
1 00 f ffffffff 00000000
2 00 f 00000000 00000000
1 00 1 000000ff 00000000
2 03 f 00000000 00000000
3 14 0 00000000 000000aa
3 08 0 00000000 000000a5
3 00 0 00000000 00000000
3 40 0 00000000 0000000d
3 7c 0 00000000 000000ef
0 00 0 00000000 00000000

//--- sim.f
logic/regfile_pkg.sv
logic/bus_pkg.sv
logic/wb_reg_port.sv
logic/file_register.sv
logic/led_panel.sv
logic/file_reg_system.sv
tests/wb_slave_checker.sv
tests/tb_file_reg_system.sv

//--- Makefile
TOP = tb_file_reg_system
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "PASS: all tests" $(LOG); then \
		echo "simulation did not finish"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
